/* Bender.yml */
package:
  name: pwm_synth

sources:
  - pwm_synth_timing_pkg.sv
  - pwm_synth_cfg_pkg.sv
  - cfg_regs.sv
  - sample_sequencer.sv
  - oscillator.sv
  - voice_filter.sv
  - pwm_out.sv
  - pwm_synth.sv
  - target: test
    files:
      - pwm_synth_checker.sv
      - tb_pwm_synth.sv

/* cfg_regs.sv */
`timescale 1ns/1ns

module cfg_regs (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic [7:0]                                cfg_data,
	input  logic [pwm_synth_cfg_pkg::CFG_ADDR_BITS-1:0] cfg_addr,
	input  logic                                      cfg_byte_sel,
	input  logic                                      cfg_strobe,
	output pwm_synth_cfg_pkg::cfg_word_u              osc_word,
	output pwm_synth_cfg_pkg::cfg_word_u              filter_word,
	output pwm_synth_cfg_pkg::cfg_word_u              misc_word
);

	logic [1:0] strobe_sync; // Bit 1 is the synchronized strobe
	logic       strobe_prev;
	logic       strobe_rise;
	logic       write_en;    // One cycle after the detected edge

	pwm_synth_cfg_pkg::cfg_word_u cfg_mem [pwm_synth_cfg_pkg::CFG_WORDS];

	// Strobe synchronizer
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_sync <= '0;
			strobe_prev <= 1'b0;
			write_en    <= 1'b0;
		end else begin
			strobe_sync <= {strobe_sync[0], cfg_strobe};
			strobe_prev <= strobe_sync[1];
			write_en    <= strobe_rise;
		end
	end

	// A strobe held high only writes once
	assign strobe_rise = strobe_sync[1] & ~strobe_prev;

	// Word storage
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < pwm_synth_cfg_pkg::CFG_WORDS; i++) begin
				cfg_mem[i] <= '1; // Octave 15 keeps the oscillator off
			end
		end else if (write_en) begin
			// Address and data are still held stable by the host here
			cfg_mem[cfg_addr].bytes[cfg_byte_sel] <= cfg_data;
		end
	end

	// Word 3 has no reader yet
	assign osc_word    = cfg_mem[pwm_synth_cfg_pkg::CFG_OSC];
	assign filter_word = cfg_mem[pwm_synth_cfg_pkg::CFG_FILTER];
	assign misc_word   = cfg_mem[pwm_synth_cfg_pkg::CFG_MISC];

endmodule

/* oscillator.sv */
`timescale 1ns/1ns

module oscillator (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic [pwm_synth_timing_pkg::STATE_BITS-1:0]   step,
	input  logic [pwm_synth_timing_pkg::DIVIDER_BITS:0]   oct_enables,
	input  logic [pwm_synth_timing_pkg::LFSR_BITS-1:0]    lfsr,
	input  pwm_synth_cfg_pkg::cfg_word_u                 osc_word,
	input  pwm_synth_cfg_pkg::cfg_word_u                 misc_word,
	output logic [pwm_synth_timing_pkg::WAVE_BITS:0]      wave
);

	localparam int OCTS = 1 << pwm_synth_timing_pkg::OCT_BITS;
	localparam int WB   = pwm_synth_timing_pkg::WAVE_BITS;

	logic [OCTS-1:0]                                 oct_sel; // Top octave never fires
	logic                                            osc_en;
	logic                                            trigger;
	logic [pwm_synth_cfg_pkg::OSC_PERIOD_BITS-1:0]   period;
	logic [pwm_synth_cfg_pkg::OSC_PERIOD_BITS-1:0]   delta;
	logic [pwm_synth_cfg_pkg::OSC_PERIOD_BITS-1:0]   counter;
	logic [WB-1:0]                                   phase;
	logic [WB-1:0]                                   next_phase;
	logic [1:0]                                      wf;

	assign wf = misc_word.bytes[0][1:0];

	// Period counter
	// ====================
	assign oct_sel = {1'b0, oct_enables[OCTS-2:0]};
	assign osc_en  = (step == pwm_synth_timing_pkg::STEP_VOL0) && oct_sel[osc_word.fields.octave];

	// Fires when taking 4 more would wrap
	assign trigger = osc_en && (counter[pwm_synth_cfg_pkg::OSC_PERIOD_BITS-1:WB] == '0);
	assign period  = {1'b1, osc_word.fields.period};
	assign delta   = (trigger ? period : '0) - (1 << WB);

	// Noise takes a fresh phase from the LFSR instead of counting
	assign next_phase = (wf == pwm_synth_cfg_pkg::WF_NOISE) ?
		{~lfsr[WB-1], lfsr[WB-2:0]} : phase + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			counter <= '0;
			phase   <= '0;
		end else if (osc_en) begin
			counter <= counter + delta;
			if (trigger) begin
				phase <= next_phase;
			end
		end
	end

	// Wave shaping, every code ends up centered around zero
	always_comb begin
		case (wf)
			pwm_synth_cfg_pkg::WF_SQUARE: wave = {~phase[WB-1], 2'b10};
			pwm_synth_cfg_pkg::WF_PULSE:  wave = {~(|phase), 2'b01}; // Narrow quarter pulse
			pwm_synth_cfg_pkg::WF_SAW,
			pwm_synth_cfg_pkg::WF_NOISE:  wave = {~phase[WB-1], phase[WB-2:0], 1'b1};
			default:                      wave = {~phase[WB-1], phase[WB-2:0], 1'b1};
		endcase
	end

endmodule

/* pwm_out.sv */
`timescale 1ns/1ns

module pwm_out (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        last_step,
	input  logic [pwm_synth_timing_pkg::FSTATE_BITS-1:0] filter_out,
	output logic                                        pwm_out
);

	localparam int FB = pwm_synth_timing_pkg::FSTATE_BITS;
	localparam int CB = pwm_synth_timing_pkg::STATE_BITS;

	logic [CB-1:0] pwm_counter;

	// High for as many cycles as were loaded
	assign pwm_out = (pwm_counter != '0);

	// PWM counter
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			pwm_counter <= '0;
		end else if (last_step) begin
			// Filter output already carries the dither here
			pwm_counter <= {~filter_out[FB-1], filter_out[FB-2 -: CB-1]};
		end else if (pwm_out) begin
			pwm_counter <= pwm_counter - 1'b1;
		end
	end

endmodule

/* pwm_synth.f */
pwm_synth_timing_pkg.sv
pwm_synth_cfg_pkg.sv
cfg_regs.sv
sample_sequencer.sv
oscillator.sv
voice_filter.sv
pwm_out.sv
pwm_synth.sv
pwm_synth_checker.sv
tb_pwm_synth.sv

/* pwm_synth.sv */
`timescale 1ns/1ns

module pwm_synth (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] cfg_data,
	input  logic [1:0] cfg_addr,
	input  logic       cfg_byte_sel,
	input  logic       cfg_strobe, // Asynchronous
	output logic       pwm_out,
	output logic [7:0] sample_out
);

	pwm_synth_cfg_pkg::cfg_word_u osc_word;
	pwm_synth_cfg_pkg::cfg_word_u filter_word;
	pwm_synth_cfg_pkg::cfg_word_u misc_word;

	logic [pwm_synth_timing_pkg::STATE_BITS-1:0]   step;
	logic                                         last_step;
	logic [pwm_synth_timing_pkg::DIVIDER_BITS:0]   oct_enables;
	logic [pwm_synth_timing_pkg::DIVIDER_BITS-1:0] oct_counter;
	logic [pwm_synth_timing_pkg::LFSR_BITS-1:0]    lfsr;
	logic [pwm_synth_timing_pkg::WAVE_BITS:0]      wave;
	logic [pwm_synth_timing_pkg::FSTATE_BITS-1:0]  filter_out;

	cfg_regs u_cfg_regs (
		.clk          (clk),
		.reset        (reset),
		.cfg_data     (cfg_data),
		.cfg_addr     (cfg_addr),
		.cfg_byte_sel (cfg_byte_sel),
		.cfg_strobe   (cfg_strobe),
		.osc_word     (osc_word),
		.filter_word  (filter_word),
		.misc_word    (misc_word)
	);

	sample_sequencer u_sample_sequencer (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.last_step   (last_step),
		.oct_enables (oct_enables),
		.oct_counter (oct_counter),
		.lfsr        (lfsr)
	);

	oscillator u_oscillator (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.oct_enables (oct_enables),
		.lfsr        (lfsr),
		.osc_word    (osc_word),
		.misc_word   (misc_word),
		.wave        (wave)
	);

	voice_filter u_voice_filter (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.wave        (wave),
		.oct_counter (oct_counter),
		.filter_word (filter_word),
		.misc_word   (misc_word),
		.filter_out  (filter_out),
		.sample_out  (sample_out)
	);

	pwm_out u_pwm_out (
		.clk        (clk),
		.reset      (reset),
		.last_step  (last_step),
		.filter_out (filter_out),
		.pwm_out    (pwm_out)
	);

endmodule

/* pwm_synth_cfg_pkg.sv */
package pwm_synth_cfg_pkg;

	// Register map
	// ====================
	localparam int CFG_WORDS     = 4;
	localparam int CFG_ADDR_BITS = 2;

	localparam int CFG_OSC    = 0; // Octave and period
	localparam int CFG_FILTER = 1; // Shift in the low nibble
	localparam int CFG_MISC   = 2; // Waveform and y/v select

	localparam int OSC_PERIOD_BITS = 10; // Counter width, period field is one less

	// Waveform codes, bits 1:0 of the misc word
	localparam logic [1:0] WF_PULSE  = 2'd0;
	localparam logic [1:0] WF_SQUARE = 2'd1;
	localparam logic [1:0] WF_NOISE  = 2'd2;
	localparam logic [1:0] WF_SAW    = 2'd3;

	// Oscillator word layout
	typedef struct packed {
		logic                                   unused_top;
		logic [1:0]                             spare;
		logic [pwm_synth_timing_pkg::OCT_BITS-1:0] octave; // 15 keeps the oscillator still
		logic [OSC_PERIOD_BITS-2:0]             period;    // Leading one is implied
	} osc_fields_t;

	// One configuration word, seen as bytes for writes or as fields for the oscillator
	typedef union packed {
		logic [1:0][7:0] bytes; // Index 0 is the low byte
		osc_fields_t     fields;
	} cfg_word_u;

endpackage

/* pwm_synth_checker.sv */
`timescale 1ns/1ns

module pwm_synth_checker (
	input logic       clk,
	input logic       reset,
	input logic [4:0] step,
	input logic       pwm_out,
	input logic       sync_strobe, // Strobe after the two sync flops
	input logic       write_en
);

	int fail_count = 0; // Failed assertions so far

	// Sequencing
	// ====================
	step_wraps: assert property (@(posedge clk) disable iff (reset)
		step == 5'd31 |=> step == 5'd0)
	else begin
		$error("step did not wrap from 31 to 0");
		fail_count++;
	end

	// PWM run always opens a sample
	pwm_rise_at_step0: assert property (@(posedge clk) disable iff (reset)
		$rose(pwm_out) |-> step == 5'd0)
	else begin
		$error("pwm_out rose outside step 0");
		fail_count++;
	end

	// Configuration writes
	// ====================
	one_write_per_edge: assert property (@(posedge clk) disable iff (reset)
		$rose(sync_strobe) |=> write_en ##1 !write_en)
	else begin
		$error("strobe edge did not give exactly one byte write");
		fail_count++;
	end

endmodule

/* pwm_synth_timing_pkg.sv */
package pwm_synth_timing_pkg;

	// Sequencer and divider
	// ====================
	localparam int STATE_BITS   = 5;  // 32 steps per sample
	localparam int DIVIDER_BITS = 17; // 14 pitch octaves plus headroom
	localparam int OCT_BITS     = 4;
	localparam int LFSR_BITS    = 15;

	// Oscillator phase
	localparam int WAVE_BITS = 2;

	// Filter datapath
	// ====================
	localparam int LEAST_SHR    = 3;  // State bits dropped on feedback
	localparam int FSTATE_BITS  = 20;
	localparam int SHIFTER_BITS = 17;
	localparam int DITHER_BITS  = 15; // Leaves 2 bits of headroom in the shifter

	// Filter steps within one sample
	localparam int STEP_VOL0     = 0; // Also the oscillator update step
	localparam int STEP_VOL1     = 1;
	localparam int STEP_DAMP     = 2;
	localparam int STEP_CUTOFF_Y = 3;
	localparam int STEP_CUTOFF_V = 4;
	localparam int STEP_OUTPUT   = 31; // PWM load happens here

endpackage

/* sample_sequencer.sv */
`timescale 1ns/1ns

module sample_sequencer (
	input  logic                                         clk,
	input  logic                                         reset,
	output logic [pwm_synth_timing_pkg::STATE_BITS-1:0]   step,
	output logic                                         last_step,
	output logic [pwm_synth_timing_pkg::DIVIDER_BITS:0]   oct_enables,
	output logic [pwm_synth_timing_pkg::DIVIDER_BITS-1:0] oct_counter,
	output logic [pwm_synth_timing_pkg::LFSR_BITS-1:0]    lfsr
);

	logic [pwm_synth_timing_pkg::STATE_BITS:0]     next_step; // Carry marks the sample end
	logic [pwm_synth_timing_pkg::DIVIDER_BITS-1:0] next_oct_counter;

	// Step counter
	// ====================
	assign next_step = step + 1'b1;
	assign last_step = next_step[pwm_synth_timing_pkg::STATE_BITS];

	// Octave divider
	// ====================
	assign next_oct_counter = oct_counter + 1'b1;

	// Bit k+1 pulses when divider bit k rises, so octave k runs at half the rate of k-1
	assign oct_enables[0] = 1'b1;
	assign oct_enables[pwm_synth_timing_pkg::DIVIDER_BITS:1] = next_oct_counter & ~oct_counter;

	always_ff @(posedge clk) begin
		if (reset) begin
			step        <= '0;
			oct_counter <= '0;
		end else begin
			step <= next_step[pwm_synth_timing_pkg::STATE_BITS-1:0];
			if (last_step) begin
				oct_counter <= next_oct_counter; // Once per sample
			end
		end
	end

	// Noise source, taps at bits 0 and 14
	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= '1;
		end else if (last_step) begin
			lfsr <= {lfsr[pwm_synth_timing_pkg::LFSR_BITS-2:0],
				lfsr[0] ^ lfsr[pwm_synth_timing_pkg::LFSR_BITS-1]};
		end
	end

endmodule

/* tb_pwm_synth.sv */
`timescale 1ns/1ns

module tb_pwm_synth;

	localparam int ROUNDS            = 16;
	localparam int SAMPLES_PER_ROUND = 400;
	localparam int TOTAL_SAMPLES     = ROUNDS * (SAMPLES_PER_ROUND + 3) + 1; // 7 writes per round
	localparam int TIMEOUT_NS        = TOTAL_SAMPLES * 32 * 100 * 12 / 10;

	logic       clk;
	logic       reset;
	logic [7:0] cfg_data;
	logic [1:0] cfg_addr;
	logic       cfg_byte_sel;
	logic       cfg_strobe;
	logic       pwm_out;
	logic [7:0] sample_out;

	int seed = 38826;

	// Reference model state
	logic [1:0]  m_sync;
	logic        m_prev;
	logic        m_wr;
	logic [15:0] m_mem [4];
	int          m_step, m_div, m_lfsr, m_cnt, m_phase, m_y, m_v, m_pwm, m_cycles;
	bit          m_valid = 0; // Set once DUT and model have both seen reset

	pwm_synth u_dut (
		.clk          (clk),
		.reset        (reset),
		.cfg_data     (cfg_data),
		.cfg_addr     (cfg_addr),
		.cfg_byte_sel (cfg_byte_sel),
		.cfg_strobe   (cfg_strobe),
		.pwm_out      (pwm_out),
		.sample_out   (sample_out)
	);

	bind pwm_synth pwm_synth_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.pwm_out     (pwm_out),
		.sync_strobe (u_cfg_regs.strobe_sync[1]),
		.write_en    (u_cfg_regs.write_en)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// One clock of the reference model
	// ====================
	task automatic model_clock();
		int wf, yv, octave, amt, src, res, w, rev;
		bit rise;
		if (reset) begin
			m_sync = '0;
			m_prev = 1'b0;
			m_wr   = 1'b0;
			for (int i = 0; i < 4; i++) begin
				m_mem[i] = 16'hffff;
			end
			{m_step, m_div, m_cnt, m_phase, m_y, m_v, m_pwm, m_cycles} = '0;
			m_lfsr  = 32'h7fff;
			m_valid = 1;
			return;
		end
		m_cycles++;
		wf     = m_mem[2][1:0];
		yv     = m_mem[2][7];
		octave = m_mem[0][12:9];
		case (wf) // Centered wave value
			0:       w = (m_phase == 0) ? -3 : 1;
			1:       w = (m_phase >= 2) ? 2 : -2;
			default: w = 2 * m_phase - 3;
		endcase
		amt = m_mem[1][3:0];
		amt = (amt == 15) ? 15 : amt + 1;
		rev = 0;
		for (int i = 0; i < 15; i++) begin
			rev[i] = m_div[14 - i];
		end
		case (m_step)
			0, 1: src = w * 16384;
			2:    src = -(m_v >>> 3) - 1;
			3:    src = m_v >>> 3;
			4:    src = -(m_y >>> 3) - 1;
			31: begin
				src = rev[14] ? rev - 32768 : rev; // Sign extend the reversed dither
				amt = 0;
			end
			default: src = 0;
		endcase
		res = src >>> amt;
		if (m_step <= 1) begin
			if (yv) m_v = res;
			else m_y = res;
		end
		if (m_step == 2 || m_step == 4) m_v = res;
		if (m_step == 3) m_y = res;
		if (m_step == 31) m_pwm = ((res >>> 15) + 16) & 31;
		else if (m_pwm != 0) m_pwm--;
		// Oscillator runs on step 0 only
		if (m_step == 0) begin
			if (octave == 0) rise = 1;
			else if (octave == 15) rise = 0;
			else rise = ((m_div + 1) >> (octave - 1)) % 2 == 1 && (m_div >> (octave - 1)) % 2 == 0;
			if (rise && m_cnt < 4) begin
				m_cnt   = (m_cnt + 512 + m_mem[0][8:0] - 4) % 1024;
				m_phase = (wf == 2) ? (m_lfsr % 4) ^ 2 : (m_phase + 1) % 4;
			end else if (rise) begin
				m_cnt = m_cnt - 4;
			end
		end
		if (m_step == 31) begin
			m_div  = (m_div + 1) % 131072;
			m_lfsr = ((m_lfsr << 1) | ((m_lfsr ^ (m_lfsr >> 14)) & 1)) & 32'h7fff;
		end
		m_step = (m_step + 1) % 32;
		// Config path, write lands one cycle after the synced edge
		if (m_wr && cfg_byte_sel) m_mem[cfg_addr][15:8] = cfg_data;
		else if (m_wr) m_mem[cfg_addr][7:0] = cfg_data;
		m_wr   = m_sync[1] & ~m_prev;
		m_prev = m_sync[1];
		m_sync = {m_sync[0], cfg_strobe};
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic sel, input logic [7:0] data);
		@(negedge clk);
		cfg_addr     = addr;
		cfg_byte_sel = sel;
		cfg_data     = data;
		cfg_strobe   = 1'b1;
		repeat (6) @(negedge clk); // Holds address and data past the write
		cfg_strobe = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) model_clock();

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (m_valid) begin
			check_value("sample_out", sample_out, ((m_y >>> 12) + 128) & 255);
			check_value("pwm_out", pwm_out, m_pwm != 0);
			if (m_cycles < 32) check_value("pwm_out after reset", pwm_out, 0);
			check_value("assertion failures", u_dut.u_checker.fail_count, 0);
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish in the expected time");
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		int octave;
		reset        = 1'b1;
		cfg_data     = '0;
		cfg_addr     = '0;
		cfg_byte_sel = 1'b0;
		cfg_strobe   = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < ROUNDS; r++) begin
			octave = $unsigned($random(seed)) % 2; // Low octave keeps the phase moving
			cfg_write(0, 0, 8'($random(seed)));
			cfg_write(0, 1, 8'(($random(seed) & 8'he1) | (octave << 1)));
			cfg_write(1, 0, 8'($random(seed)));
			cfg_write(1, 1, 8'($random(seed)));
			cfg_write(2, 0, 8'(($random(seed) & 8'h80) | (r % 4))); // Every waveform in turn
			cfg_write(2, 1, 8'($random(seed)));
			cfg_write(3, 1'(r % 2), 8'($random(seed)));
			repeat (SAMPLES_PER_ROUND * 32) @(negedge clk);
		end
		check_value("assertion failures", u_dut.u_checker.fail_count, 0);
		$display("Test passed");
		$finish;
	end

endmodule

/* voice_filter.sv */
`timescale 1ns/1ns

module voice_filter (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic [pwm_synth_timing_pkg::STATE_BITS-1:0]   step,
	input  logic [pwm_synth_timing_pkg::WAVE_BITS:0]      wave,
	input  logic [pwm_synth_timing_pkg::DIVIDER_BITS-1:0] oct_counter,
	input  pwm_synth_cfg_pkg::cfg_word_u                 filter_word,
	input  pwm_synth_cfg_pkg::cfg_word_u                 misc_word,
	output logic [pwm_synth_timing_pkg::FSTATE_BITS-1:0]  filter_out,
	output logic [7:0]                                   sample_out
);

	localparam int FB  = pwm_synth_timing_pkg::FSTATE_BITS;
	localparam int SB  = pwm_synth_timing_pkg::SHIFTER_BITS;
	localparam int DB  = pwm_synth_timing_pkg::DITHER_BITS;
	localparam int LSR = pwm_synth_timing_pkg::LEAST_SHR;
	localparam int OB  = pwm_synth_timing_pkg::OCT_BITS;

	logic signed [FB-1:0] y;
	logic signed [FB-1:0] v;

	logic                 yv_sel;  // 1 sends the voice into v
	logic                 write_y;
	logic                 write_v;
	logic        [SB-1:0] shifter_src;
	logic        [SB-1:0] dither;
	logic        [OB:0]   shift_sum;
	logic        [OB-1:0] shift_amt;
	logic signed [FB-1:0] shifted;

	assign yv_sel = misc_word.bytes[0][7];

	// Dither is the divider low bits reversed, so it changes fastest at the top
	always_comb begin
		dither = {SB{oct_counter[0]}}; // Sign of the reversed value
		for (int i = 0; i < DB; i++) begin
			dither[i] = oct_counter[DB-1-i];
		end
	end

	// Step decode
	// ====================
	always_comb begin
		write_y     = 1'b0;
		write_v     = 1'b0;
		shifter_src = '0;
		case (step)
			pwm_synth_timing_pkg::STEP_VOL0,
			pwm_synth_timing_pkg::STEP_VOL1: begin
				write_y     = ~yv_sel;
				write_v     = yv_sel;
				shifter_src = {wave, {(SB-pwm_synth_timing_pkg::WAVE_BITS-1){1'b0}}};
			end
			pwm_synth_timing_pkg::STEP_DAMP: begin
				write_v     = 1'b1;
				shifter_src = ~v[FB-1:LSR]; // Inverting is close enough to negating
			end
			pwm_synth_timing_pkg::STEP_CUTOFF_Y: begin
				write_y     = 1'b1;
				shifter_src = v[FB-1:LSR];
			end
			pwm_synth_timing_pkg::STEP_CUTOFF_V: begin
				write_v     = 1'b1;
				shifter_src = ~y[FB-1:LSR];
			end
			pwm_synth_timing_pkg::STEP_OUTPUT: begin
				shifter_src = dither; // Result only feeds the PWM load
			end
			default: begin
				shifter_src = '0;
			end
		endcase
	end

	// Shifter
	// ====================
	assign shift_sum = {1'b0, filter_word.bytes[0][OB-1:0]} + 1'b1;

	always_comb begin
		if (step == pwm_synth_timing_pkg::STEP_OUTPUT) begin
			shift_amt = '0;
		end else if (shift_sum[OB]) begin
			shift_amt = '1; // Saturate at 15
		end else begin
			shift_amt = shift_sum[OB-1:0];
		end
	end

	assign shifted    = $signed({{(FB-SB){shifter_src[SB-1]}}, shifter_src}) >>> shift_amt;
	assign filter_out = shifted;

	always_ff @(posedge clk) begin
		if (reset) begin
			y <= '0;
			v <= '0;
		end else begin
			if (write_y) begin
				y <= shifted;
			end
			if (write_v) begin
				v <= shifted;
			end
		end
	end

	// Offset binary out of the top of y
	assign sample_out = {~y[FB-1], y[FB-2 -: 7]};

endmodule
